//--- Bender.yml
package:
  name: direct_mapped_cache

sources:
  - design/cache_pkg.sv
  - design/byte_ram.sv
  - design/cache_lookup.sv
  - design/burst_ctrl.sv
  - design/cache_top.sv
  - target: test
    files:
      - test/burst_ram_model.sv
      - test/tb_cache.sv

//--- design/burst_ctrl.sv
// burst_ctrl
// sequences line refills and dirty line evictions on the burst RAM port
// and keeps consecutive commands apart by a minimum interval

`timescale 1ns/1ps

module burst_ctrl #(
  parameter int ram_depth_width = 21,
  parameter int cmd_interval_cycles = 13
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       miss,
  input  logic                       line_dirty,
  input  logic [ram_depth_width-1:0] victim_addr,
  input  logic [ram_depth_width-1:0] line_addr,
  input  cache_pkg::beat_t           pair_data,
  output logic [1:0]                 pair_ix,
  output cache_pkg::fill_wr_t        fill,
  output logic                       tag_commit,
  output logic                       filling,
  output logic                       busy_ctrl,
  output logic                       br_cmd,
  output logic                       br_cmd_en,
  output logic [ram_depth_width-1:0] br_addr,
  output cache_pkg::beat_t           br_wr_data,
  input  cache_pkg::beat_t           br_rd_data,
  input  logic                       br_rd_data_valid
);

  localparam int cnt_width = $clog2(cmd_interval_cycles + 1);
  localparam logic [1:0] last_beat = 2'(cache_pkg::beats_per_line - 1);

  cache_pkg::burst_state_t state;
  logic [1:0] beat_cnt;
  logic [cnt_width-1:0] cmd_cnt;

  logic start;
  logic issue_wr;
  logic issue_rd;
  logic take_beat;

  logic fill_we;
  logic [1:0] fill_pair;
  cache_pkg::beat_t fill_data;

  // a miss seen in idle once the interval has run out
  assign start = state == cache_pkg::idle && miss && cmd_cnt == '0;
  assign issue_wr = start && line_dirty;
  assign issue_rd = (start && !line_dirty) || (state == cache_pkg::wr_gap && cmd_cnt == '0);

  // beat 0 arrives in rd_wait, beats 1 to 3 while beat_cnt is nonzero
  assign take_beat = (state == cache_pkg::rd_wait && br_rd_data_valid) ||
                     (state == cache_pkg::rd_beat && beat_cnt != '0);

  assign pair_ix = beat_cnt;
  assign fill = '{we: fill_we, pair: fill_pair, data: fill_data};
  assign tag_commit = state == cache_pkg::rd_tag;
  assign filling = state inside {cache_pkg::rd_wait, cache_pkg::rd_beat,
                                 cache_pkg::rd_tag, cache_pkg::rd_done};
  assign busy_ctrl = cmd_cnt != '0 || state != cache_pkg::idle;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cache_pkg::idle;
      beat_cnt <= '0;
      cmd_cnt <= '0;
      br_cmd_en <= 1'b0;
      fill_we <= 1'b0;
    end else begin
      br_cmd_en <= issue_wr || issue_rd;
      fill_we <= take_beat;

      // interval counter reloads on every command
      if (issue_wr || issue_rd) begin
        cmd_cnt <= cnt_width'(cmd_interval_cycles);
      end else if (cmd_cnt != '0) begin
        cmd_cnt <= cmd_cnt - 1'b1;
      end

      // wraps back to zero after the last beat of either direction
      if (issue_wr || state == cache_pkg::wr_beat || take_beat) begin
        beat_cnt <= beat_cnt + 1'b1;
      end

      case (state)
        cache_pkg::idle: begin
          if (issue_wr) begin
            state <= cache_pkg::wr_beat;
          end else if (issue_rd) begin
            state <= cache_pkg::rd_wait;
          end
        end
        cache_pkg::wr_beat: begin
          if (beat_cnt == last_beat) begin
            state <= cache_pkg::wr_gap;
          end
        end
        cache_pkg::wr_gap: begin
          if (issue_rd) begin
            state <= cache_pkg::rd_wait;
          end
        end
        cache_pkg::rd_wait: begin
          if (br_rd_data_valid) begin
            state <= cache_pkg::rd_beat;
          end
        end
        cache_pkg::rd_beat: begin
          // last pair is being written this cycle
          if (beat_cnt == '0) begin
            state <= cache_pkg::rd_tag;
          end
        end
        cache_pkg::rd_tag: begin
          state <= cache_pkg::rd_done;
        end
        cache_pkg::rd_done: begin
          state <= cache_pkg::idle;
        end
        default: begin
          state <= cache_pkg::idle;
        end
      endcase
    end
  end

  // command, address and beat data
  always_ff @(posedge clk) begin
    if (issue_wr || issue_rd) begin
      br_cmd <= issue_wr;
      br_addr <= issue_wr ? victim_addr : line_addr;
    end
    if (issue_wr || state == cache_pkg::wr_beat) begin
      br_wr_data <= pair_data;
    end
    if (take_beat) begin
      fill_pair <= beat_cnt;
      fill_data <= br_rd_data;
    end
  end

  // every command pulse is followed by a quiet interval of the programmed length
  assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en [* cmd_interval_cycles])
    else $error("burst commands closer than the command interval");

endmodule

//--- design/byte_ram.sv
// byte_ram
// byte-enabled block RAM with one address shared by write and read
// the registered read returns the old word on a write cycle

`timescale 1ns/1ps

module byte_ram #(
  parameter int addr_width = 8
) (
  input  logic                  clk,
  input  cache_pkg::wstrb_t     we,
  input  logic [addr_width-1:0] addr,
  input  cache_pkg::word_t      wdata,
  output cache_pkg::word_t      rdata
);

  localparam int n_bytes = $bits(cache_pkg::wstrb_t);

  // starts all zero, so every tag entry begins invalid
  logic [n_bytes-1:0][7:0] mem [2**addr_width] = '{default: '0};

  always_ff @(posedge clk) begin
    for (int b = 0; b < n_bytes; b++) begin
      if (we[b]) begin
        mem[addr][b] <= wdata[8*b +: 8];
      end
    end
    // read before write
    rdata <= mem[addr];
  end

endmodule

//--- design/cache_lookup.sv
// cache_lookup
// splits the request address, keeps tags and line data in block RAM,
// detects hits, merges write hits and steers refill beats into the columns

`timescale 1ns/1ps

module cache_lookup #(
  parameter int line_index_width = 8,
  parameter int ram_depth_width = 21,
  parameter int ram_addr_mode = 0
) (
  input  logic                       clk,
  input  cache_pkg::cache_req_t      req,
  output cache_pkg::word_t           rdata,
  output logic                       rdata_ready,
  output logic                       miss,
  output logic                       line_dirty,
  output logic [ram_depth_width-1:0] victim_addr,
  output logic [ram_depth_width-1:0] line_addr,
  input  logic [1:0]                 pair_ix,
  output cache_pkg::beat_t           pair_data,
  input  cache_pkg::fill_wr_t        fill,
  input  logic                       tag_commit,
  input  logic                       filling
);

  localparam int offset_bits = cache_pkg::col_bits + cache_pkg::zero_bits;
  localparam int tag_width = 32 - line_index_width - offset_bits;
  // line number to RAM address, RAM words are 2^ram_addr_mode bytes
  localparam int line_shift = offset_bits - ram_addr_mode;

  typedef logic [tag_width-1:0] tag_t;
  typedef logic [line_index_width-1:0] line_ix_t;

  // address layout |tag|line|col|00|
  cache_pkg::col_ix_t col_ix;
  line_ix_t line_ix;
  line_ix_t line_ix_q;
  tag_t req_tag;
  tag_t stored_tag;
  logic stored_valid;
  logic lookup_valid;
  logic hit;
  logic proc_we;

  cache_pkg::wstrb_t tag_we;
  cache_pkg::word_t tag_wdata;
  cache_pkg::word_t tag_rdata;

  cache_pkg::wstrb_t col_we [cache_pkg::cols_per_line];
  cache_pkg::word_t col_wdata [cache_pkg::cols_per_line];
  cache_pkg::word_t col_rdata [cache_pkg::cols_per_line];

  assign col_ix = req.address[cache_pkg::zero_bits +: cache_pkg::col_bits];
  assign line_ix = req.address[offset_bits +: line_index_width];
  assign req_tag = req.address[31 -: tag_width];

  // RAM outputs belong to the line index of the previous cycle
  always_ff @(posedge clk) begin
    line_ix_q <= line_ix;
  end

  // tag store word is {dirty, valid, tag}
  assign stored_tag = tag_rdata[tag_width-1:0];
  assign stored_valid = tag_rdata[tag_width];
  assign line_dirty = tag_rdata[tag_width+1];

  // no hit and no miss while the RAMs still show another line
  assign lookup_valid = line_ix_q == line_ix;
  assign hit = lookup_valid && stored_valid && stored_tag == req_tag;
  assign miss = req.enable && lookup_valid && !hit;

  assign proc_we = req.enable && req.wstrb != '0 && hit && !filling;

  assign rdata = col_rdata[col_ix];
  assign rdata_ready = req.enable && req.wstrb == '0 && hit;

  // line start addresses in the burst RAM
  assign line_addr = ram_depth_width'({req_tag, line_ix, {line_shift{1'b0}}});
  assign victim_addr = ram_depth_width'({stored_tag, line_ix, {line_shift{1'b0}}});

  // victim beat for the eviction, low word in the even column
  assign pair_data = {col_rdata[{pair_ix, 1'b1}], col_rdata[{pair_ix, 1'b0}]};

  // refill commits a clean tag, a write hit marks the line dirty
  assign tag_we = {$bits(cache_pkg::wstrb_t){filling ? tag_commit : proc_we}};
  assign tag_wdata = cache_pkg::word_t'({!filling, 1'b1, req_tag});

  byte_ram #(
    .addr_width(line_index_width)
  ) u_tag (
    .clk  (clk),
    .we   (tag_we),
    .addr (line_ix),
    .wdata(tag_wdata),
    .rdata(tag_rdata)
  );

  for (genvar i = 0; i < cache_pkg::cols_per_line; i++) begin : g_col
    // the controller owns the columns during a refill
    always_comb begin
      if (filling) begin
        col_we[i] = (fill.we && fill.pair == 2'(i / 2)) ? '1 : '0;
        col_wdata[i] = fill.data[32*(i%2) +: 32];
      end else begin
        col_we[i] = (proc_we && col_ix == cache_pkg::col_ix_t'(i)) ? req.wstrb : '0;
        col_wdata[i] = req.wdata;
      end
    end

    byte_ram #(
      .addr_width(line_index_width)
    ) u_col (
      .clk  (clk),
      .we   (col_we[i]),
      .addr (line_ix),
      .wdata(col_wdata[i]),
      .rdata(col_rdata[i])
    );
  end

  // a refill in progress never meets a processor write hit on the same line
  assert property (@(posedge clk) filling |-> !(req.enable && req.wstrb != '0 && hit))
    else $error("processor write hit while the controller is filling");

endmodule

//--- design/cache_pkg.sv
// cache_pkg
// shared types and line geometry of the direct-mapped write-back data cache
// words, burst beats, byte enables, the processor request and refill beats

package cache_pkg;

  // data widths seen on the processor and burst RAM sides
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [3:0] wstrb_t;
  typedef logic [2:0] col_ix_t;

  // a line holds eight words and moves as four 64-bit beats
  localparam int col_bits = 3;
  localparam int zero_bits = 2;
  localparam int cols_per_line = 8;
  localparam int beats_per_line = 4;

  // processor request
  // held by the requester while busy and for one cycle after busy falls
  typedef struct packed {
    logic enable;
    logic [31:0] address;
    word_t wdata;
    wstrb_t wstrb;  // all zero for a read
  } cache_req_t;

  // one refill beat, written into a pair of neighbouring columns
  typedef struct packed {
    logic we;
    logic [1:0] pair;
    beat_t data;
  } fill_wr_t;

  // refill and eviction sequencer states
  typedef enum logic [2:0] {
    idle,
    rd_wait,
    rd_beat,
    rd_tag,
    rd_done,
    wr_beat,
    wr_gap
  } burst_state_t;

endpackage

//--- design/cache_top.sv
// cache_top
// direct-mapped write-back data cache between a 32-bit processor port
// and a 64-bit burst PSRAM controller port

`timescale 1ns/1ps

module cache_top #(
  parameter int line_index_width = 8,
  parameter int ram_depth_width = 21,
  parameter int cmd_interval_cycles = 13,
  parameter int ram_addr_mode = 0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cache_pkg::cache_req_t      req,
  output cache_pkg::word_t           rdata,
  output logic                       rdata_ready,
  output logic                       busy,
  output logic                       br_cmd,
  output logic                       br_cmd_en,
  output logic [ram_depth_width-1:0] br_addr,
  output cache_pkg::beat_t           br_wr_data,
  output logic [7:0]                 br_data_mask,
  input  cache_pkg::beat_t           br_rd_data,
  input  logic                       br_rd_data_valid
);

  logic miss;
  logic line_dirty;
  logic [ram_depth_width-1:0] victim_addr;
  logic [ram_depth_width-1:0] line_addr;
  logic [1:0] pair_ix;
  cache_pkg::beat_t pair_data;
  cache_pkg::fill_wr_t fill;
  logic tag_commit;
  logic filling;
  logic busy_ctrl;

  assign busy = miss || busy_ctrl;
  // whole lines are always written
  assign br_data_mask = '0;

  cache_lookup #(
    .line_index_width(line_index_width),
    .ram_depth_width (ram_depth_width),
    .ram_addr_mode   (ram_addr_mode)
  ) u_lookup (
    .clk        (clk),
    .req        (req),
    .rdata      (rdata),
    .rdata_ready(rdata_ready),
    .miss       (miss),
    .line_dirty (line_dirty),
    .victim_addr(victim_addr),
    .line_addr  (line_addr),
    .pair_ix    (pair_ix),
    .pair_data  (pair_data),
    .fill       (fill),
    .tag_commit (tag_commit),
    .filling    (filling)
  );

  burst_ctrl #(
    .ram_depth_width    (ram_depth_width),
    .cmd_interval_cycles(cmd_interval_cycles)
  ) u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .miss            (miss),
    .line_dirty      (line_dirty),
    .victim_addr     (victim_addr),
    .line_addr       (line_addr),
    .pair_data       (pair_data),
    .pair_ix         (pair_ix),
    .fill            (fill),
    .tag_commit      (tag_commit),
    .filling         (filling),
    .busy_ctrl       (busy_ctrl),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

endmodule

//--- flist.f
design/cache_pkg.sv
design/byte_ram.sv
design/cache_lookup.sv
design/burst_ctrl.sv
design/cache_top.sv
test/burst_ram_model.sv
test/tb_cache.sv

//--- test/burst_ram_model.sv
// burst_ram_model
// behavioral burst RAM on the 64-bit PSRAM controller port
// a read command is answered by four consecutive beats after a fixed delay,
// a write burst brings beat 0 with the command and three beats after it

`timescale 1ns/1ps

module burst_ram_model #(
  parameter int addr_width = 21,
  parameter int mem_width = 12,
  parameter int read_latency = 5,
  parameter logic [7:0] fill_pattern = 8'h5a
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd,
  input  logic                  cmd_en,
  input  logic [addr_width-1:0] addr,
  input  cache_pkg::beat_t      wr_data,
  input  logic [7:0]            data_mask,
  output cache_pkg::beat_t      rd_data,
  output logic                  rd_data_valid
);

  localparam int beats_per_line = 4;

  // byte wide storage, the address wraps at 2^mem_width bytes
  logic [7:0] mem [2**mem_width];
  logic [mem_width-1:0] wr_base;
  logic [mem_width-1:0] rd_base;
  int wr_beat;
  int rd_timer;

  initial begin
    for (int a = 0; a < 2**mem_width; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ fill_pattern;
    end
  end

  task automatic store_beat(input logic [mem_width-1:0] base, input int k);
    for (int b = 0; b < 8; b++) begin
      if (!data_mask[b]) begin
        mem[mem_width'(base + 8*k + b)] = wr_data[8*b +: 8];
      end
    end
  endtask

  function automatic cache_pkg::beat_t load_beat(input logic [mem_width-1:0] base, input int k);
    cache_pkg::beat_t beat;
    for (int b = 0; b < 8; b++) begin
      beat[8*b +: 8] = mem[mem_width'(base + 8*k + b)];
    end
    return beat;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_base <= '0;
      rd_base <= '0;
      wr_beat <= 0;
      rd_timer <= 0;
      rd_data <= '0;
      rd_data_valid <= 1'b0;
    end else begin
      // write burst, beat 0 comes with the command
      if (cmd_en && cmd) begin
        store_beat(addr[mem_width-1:0], 0);
        wr_base <= addr[mem_width-1:0];
        wr_beat <= 1;
      end else if (wr_beat != 0) begin
        store_beat(wr_base, wr_beat);
        wr_beat <= (wr_beat == beats_per_line - 1) ? 0 : wr_beat + 1;
      end

      // read burst after the fixed delay
      if (cmd_en && !cmd) begin
        rd_base <= addr[mem_width-1:0];
        rd_timer <= 1;
      end else if (rd_timer != 0) begin
        rd_timer <= (rd_timer == read_latency + beats_per_line - 1) ? 0 : rd_timer + 1;
      end
      if (rd_timer >= read_latency) begin
        rd_data_valid <= 1'b1;
        rd_data <= load_beat(rd_base, rd_timer - read_latency);
      end else begin
        rd_data_valid <= 1'b0;
      end
    end
  end

endmodule

//--- test/tb_cache.sv
// tb_cache
// directed testbench for the direct-mapped write-back data cache
// a behavioral burst RAM sits on the PSRAM side and a byte-wide
// reference memory predicts every read

`timescale 1ns/1ps

module tb_cache;

  localparam int line_index_width = 4;
  localparam int ram_depth_width = 21;
  localparam int cmd_interval_cycles = 13;
  localparam int mem_width = 12;
  localparam logic [7:0] fill_pattern = 8'h5a;
  localparam int timeout_cycles = 200;
  localparam logic [31:0] first_addr = 32'h0000_0124;
  // same line index, next tag up
  localparam logic [31:0] alias_addr = 32'h0000_0324;

  logic clk;
  logic rst_n;
  cache_pkg::cache_req_t req;
  cache_pkg::word_t rdata;
  logic rdata_ready;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  logic [ram_depth_width-1:0] br_addr;
  cache_pkg::beat_t br_wr_data;
  logic [7:0] br_data_mask;
  cache_pkg::beat_t br_rd_data;
  logic br_rd_data_valid;

  logic [7:0] ref_mem [2**mem_width];
  logic [31:0] lcg_state;

  // burst RAM traffic seen by the monitor
  int cycle_no = 0;
  int wr_follow = 0;
  logic cmd_dir_q [$];
  logic [ram_depth_width-1:0] cmd_addr_q [$];
  int cmd_cycle_q [$];
  cache_pkg::beat_t wr_beat_q [$];

  cache_top #(
    .line_index_width   (line_index_width),
    .ram_depth_width    (ram_depth_width),
    .cmd_interval_cycles(cmd_interval_cycles),
    .ram_addr_mode      (0)
  ) u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (req),
    .rdata           (rdata),
    .rdata_ready     (rdata_ready),
    .busy            (busy),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_data_mask    (br_data_mask),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram_model #(
    .addr_width  (ram_depth_width),
    .mem_width   (mem_width),
    .read_latency(5),
    .fill_pattern(fill_pattern)
  ) u_ram (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (br_cmd),
    .cmd_en       (br_cmd_en),
    .addr         (br_addr),
    .wr_data      (br_wr_data),
    .data_mask    (br_data_mask),
    .rd_data      (br_rd_data),
    .rd_data_valid(br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // commands and write beats, sampled mid-cycle
  always @(negedge clk) begin
    cycle_no++;
    if (rst_n) begin
      if (br_cmd_en) begin
        cmd_dir_q.push_back(br_cmd);
        cmd_addr_q.push_back(br_addr);
        cmd_cycle_q.push_back(cycle_no);
      end
      // whole-line writes carry no byte mask
      if ((br_cmd_en && br_cmd) || wr_follow != 0) begin
        expect_eq("br_data_mask", 8'h00, br_data_mask);
      end
      if (br_cmd_en && br_cmd) begin
        wr_beat_q.push_back(br_wr_data);
        wr_follow = 3;
      end else if (wr_follow != 0) begin
        wr_beat_q.push_back(br_wr_data);
        wr_follow--;
      end
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp)
      else stop_with_error($sformatf("ERROR %s exp %h got %h", name, exp, got));
  endtask

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic logic [31:0] line_base(input logic [31:0] addr);
    return addr & ~32'h1f;
  endfunction

  function automatic cache_pkg::word_t ref_word(input logic [31:0] addr);
    logic [mem_width-1:0] a;
    a = addr[mem_width-1:0];
    return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
  endfunction

  function automatic cache_pkg::beat_t ref_beat(input logic [31:0] line, input int k);
    return {ref_word(line + 8*k + 4), ref_word(line + 8*k)};
  endfunction

  task automatic ref_write(input logic [31:0] addr, input cache_pkg::wstrb_t strb,
                           input cache_pkg::word_t data);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        ref_mem[mem_width'(addr + b)] = data[8*b +: 8];
      end
    end
  endtask

  // one request: wait out busy, hold one more cycle, then a cycle with enable low
  task automatic access(input logic [31:0] addr, input cache_pkg::wstrb_t strb,
                        input cache_pkg::word_t wdata, output cache_pkg::word_t got,
                        output int busy_cycles);
    req.enable = 1'b1;
    req.address = addr;
    req.wdata = wdata;
    req.wstrb = strb;
    busy_cycles = 0;
    @(negedge clk);
    while (busy) begin
      busy_cycles++;
      assert (busy_cycles < timeout_cycles)
        else stop_with_error($sformatf("request to %h still busy after timeout", addr));
      @(negedge clk);
    end
    // a write lands on the edge before this one
    @(negedge clk);
    got = '0;
    if (strb == '0) begin
      expect_eq("rdata_ready", 1'b1, rdata_ready);
      got = rdata;
    end
    req.enable = 1'b0;
    @(negedge clk);
  endtask

  task automatic check_idle_after_reset();
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      expect_eq("busy", 1'b0, busy);
      expect_eq("br_cmd_en", 1'b0, br_cmd_en);
    end
    expect_eq("command count", 0, cmd_dir_q.size());
  endtask

  task automatic check_read_miss();
    int n_cmd;
    int busy_cycles;
    cache_pkg::word_t got;
    n_cmd = cmd_dir_q.size();
    access(first_addr, '0, '0, got, busy_cycles);
    expect_eq("command count", n_cmd + 1, cmd_dir_q.size());
    expect_eq("br_cmd", 1'b0, cmd_dir_q[n_cmd]);
    expect_eq("br_addr", line_base(first_addr), cmd_addr_q[n_cmd]);
    expect_eq("rdata", ref_word(first_addr), got);
  endtask

  task automatic check_line_hits();
    int n_cmd;
    int busy_cycles;
    logic [31:0] addr;
    cache_pkg::word_t got;
    n_cmd = cmd_dir_q.size();
    for (int c = 0; c < 8; c++) begin
      addr = line_base(first_addr) + 4*c;
      if (addr != first_addr) begin
        access(addr, '0, '0, got, busy_cycles);
        expect_eq("busy cycles", 0, busy_cycles);
        expect_eq("rdata", ref_word(addr), got);
      end
    end
    expect_eq("command count", n_cmd, cmd_dir_q.size());
  endtask

  task automatic check_write_hit();
    int busy_cycles;
    cache_pkg::word_t got;
    access(first_addr, 4'b0110, 32'hc3a5_5a3c, got, busy_cycles);
    expect_eq("busy cycles", 0, busy_cycles);
    ref_write(first_addr, 4'b0110, 32'hc3a5_5a3c);
    access(first_addr, '0, '0, got, busy_cycles);
    expect_eq("rdata", ref_word(first_addr), got);
  endtask

  task automatic check_eviction();
    int n_cmd;
    int n_beat;
    int busy_cycles;
    cache_pkg::word_t got;
    n_cmd = cmd_dir_q.size();
    n_beat = wr_beat_q.size();
    access(alias_addr, '0, '0, got, busy_cycles);
    expect_eq("command count", n_cmd + 2, cmd_dir_q.size());
    expect_eq("br_cmd", 1'b1, cmd_dir_q[n_cmd]);
    expect_eq("br_addr", line_base(first_addr), cmd_addr_q[n_cmd]);
    expect_eq("write beat count", n_beat + 4, wr_beat_q.size());
    for (int k = 0; k < 4; k++) begin
      expect_eq("br_wr_data", ref_beat(line_base(first_addr), k), wr_beat_q[n_beat + k]);
    end
    expect_eq("br_cmd", 1'b0, cmd_dir_q[n_cmd + 1]);
    expect_eq("br_addr", line_base(alias_addr), cmd_addr_q[n_cmd + 1]);
    assert (cmd_cycle_q[n_cmd + 1] - cmd_cycle_q[n_cmd] >= cmd_interval_cycles + 1)
      else stop_with_error("refill read came too soon after the eviction write");
    expect_eq("rdata", ref_word(alias_addr), got);
  endtask

  // reads and masked writes over a 2 KB window
  task automatic run_random_mix();
    logic [15:0] r;
    logic [31:0] addr;
    cache_pkg::wstrb_t strb;
    cache_pkg::word_t wdata;
    cache_pkg::word_t got;
    int busy_cycles;
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      addr = {21'b0, r[10:2], 2'b00};
      if (r[15]) begin
        strb = cache_pkg::wstrb_t'(next_rand());
        if (strb == '0) begin
          strb = 4'b1111;
        end
        wdata = {next_rand(), next_rand()};
        access(addr, strb, wdata, got, busy_cycles);
        ref_write(addr, strb, wdata);
      end else begin
        access(addr, '0, '0, got, busy_cycles);
        expect_eq("rdata", ref_word(addr), got);
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    req = '0;
    lcg_state = 32'd53265;
    for (int a = 0; a < 2**mem_width; a++) begin
      ref_mem[a] = 8'(a) ^ 8'(a >> 8) ^ fill_pattern;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_idle_after_reset();
    check_read_miss();
    check_line_hits();
    check_write_hit();
    check_eviction();
    run_random_mix();
    $display("Testbench passed");
    $finish;
  end

endmodule
